// File: Makefile
TOP = execute_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f compile.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: compile.f
logic/exec_pkg.sv
logic/operand_bypass.sv
logic/integer_alu.sv
logic/multiply_pipeline.sv
logic/branch_resolver.sv
logic/execute_stage.sv
tests/execute_stage_chk.sv
tests/execute_stage_tb.sv

// File: logic/branch_resolver.sv
////////////////////////////////////////////////////////////////////////////
// Resolves branches and PC writes in the cycle they sit in decode.
// An ALU write to REG_PC is a taken jump to the ALU result.
// Rollback is raised when the outcome differs from the prediction.
////////////////////////////////////////////////////////////////////////////

module branch_resolver(
	input  logic                        valid_i,
	input  logic                        squash_i,
	input  logic                        branch_i,
	input  exec_pkg::branch_t           branch_type_i,
	input  logic [exec_pkg::DATA_W-1:0] offset_i,
	input  logic [exec_pkg::DATA_W-1:0] pc_i,
	input  logic [exec_pkg::DATA_W-1:0] operand1_i,
	input  logic [exec_pkg::DATA_W-1:0] alu_result_i,
	input  logic                        writes_pc_i,
	input  logic                        predicted_i,
	output logic                        taken_o,
	output logic                        rollback_request_o,
	output logic [exec_pkg::DATA_W-1:0] rollback_pc_o
);

	logic                        taken;
	logic [exec_pkg::DATA_W-1:0] target;

	always_comb
	begin
		taken = 1'b0;
		target = pc_i + offset_i;
		if (writes_pc_i)
		begin
			taken = 1'b1;
			target = alu_result_i;
		end
		else if (branch_i)
		begin
			case (branch_type_i)
				exec_pkg::BRANCH_ZERO:     taken = operand1_i == '0;
				exec_pkg::BRANCH_NOT_ZERO: taken = operand1_i != '0;
				// Always and both calls
				default:                   taken = 1'b1;
			endcase

			if (branch_type_i == exec_pkg::BRANCH_CALL_REGISTER)
				target = operand1_i;
		end
	end

	assign taken_o = taken;
	assign rollback_request_o = valid_i && !squash_i && (taken != predicted_i);

	// Not taken but predicted taken resumes at the branch's own PC
	assign rollback_pc_o = taken ? target : pc_i;

endmodule

// File: logic/exec_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, constants and enums of the scalar execute stage.
// Register REG_PC is not a storage register. Any read of it returns the
// PC of the reading instruction, and a write to it is a jump.
// Multiply is the only operation that does not finish in one cycle.
////////////////////////////////////////////////////////////////////////////

package exec_pkg;

	// Datapath and PC width
	localparam int DATA_W = 32;

	// Register number and strand id widths
	localparam int REG_SEL_W = 5;
	localparam int STRAND_W = 2;

	// Register that reads as the instruction's own PC
	localparam logic [REG_SEL_W-1:0] REG_PC = 5'd31;

	// Depth of the multiply pipeline
	localparam int MUL_STAGES = 3;

	// ALU operations where compares give 0 or 1
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_SEQ,
		ALU_SLTU,
		ALU_MOVE,
		ALU_MUL
	} alu_op_t;

	// Where operand 2 comes from
	typedef enum logic {
		OP2_SRC_REG2,
		OP2_SRC_IMMEDIATE
	} op2_src_t;

	// Branch kinds
	typedef enum logic [2:0] {
		BRANCH_ZERO,
		BRANCH_NOT_ZERO,
		BRANCH_ALWAYS,
		BRANCH_CALL_OFFSET,
		BRANCH_CALL_REGISTER
	} branch_t;

endpackage

// File: logic/execute_stage.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage: operand bypass, single-cycle ALU, multiply pipeline and
// branch resolution. The multiply and single-cycle paths share one output
// register. Decode must not send a single-cycle op in the cycle a multiply
// reaches the merge, since the multiply wins and nothing here stalls.
////////////////////////////////////////////////////////////////////////////

module execute_stage(
	input  logic                            clk,
	input  logic                            reset,

	// From decode
	input  logic                            ds_valid_i,
	input  logic [exec_pkg::STRAND_W-1:0]   ds_strand_i,
	input  logic [exec_pkg::DATA_W-1:0]     ds_pc_i,
	input  logic [exec_pkg::REG_SEL_W-1:0]  ds_sel1_i,
	input  logic [exec_pkg::REG_SEL_W-1:0]  ds_sel2_i,
	input  logic [exec_pkg::DATA_W-1:0]     ds_immediate_i,
	input  exec_pkg::op2_src_t              ds_op2_src_i,
	input  exec_pkg::alu_op_t               ds_alu_op_i,
	input  logic [exec_pkg::REG_SEL_W-1:0]  ds_writeback_reg_i,
	input  logic                            ds_enable_writeback_i,
	input  logic                            ds_branch_i,
	input  exec_pkg::branch_t               ds_branch_type_i,
	input  logic [exec_pkg::DATA_W-1:0]     ds_branch_offset_i,
	input  logic                            ds_branch_predicted_i,

	// Register file reads
	input  logic [exec_pkg::DATA_W-1:0]     scalar_value1_i,
	input  logic [exec_pkg::DATA_W-1:0]     scalar_value2_i,

	// Bypass from later stages
	input  logic [exec_pkg::REG_SEL_W-1:0]  ma_writeback_reg_i,
	input  logic                            ma_enable_writeback_i,
	input  logic [exec_pkg::DATA_W-1:0]     ma_value_i,
	input  logic [exec_pkg::REG_SEL_W-1:0]  wb_writeback_reg_i,
	input  logic                            wb_enable_writeback_i,
	input  logic [exec_pkg::DATA_W-1:0]     wb_value_i,
	input  logic [exec_pkg::REG_SEL_W-1:0]  rf_writeback_reg_i,
	input  logic                            rf_enable_writeback_i,
	input  logic [exec_pkg::DATA_W-1:0]     rf_value_i,

	// Rollback controller
	input  logic                            squash_ex0_i,
	input  logic                            squash_ex1_i,
	input  logic                            squash_ex2_i,
	input  logic                            squash_ex3_i,
	output logic                            ex_rollback_request_o,
	output logic [exec_pkg::DATA_W-1:0]     ex_rollback_pc_o,

	// To memory access stage
	output logic                            ex_valid_o,
	output logic [exec_pkg::STRAND_W-1:0]   ex_strand_o,
	output logic [exec_pkg::DATA_W-1:0]     ex_pc_o,
	output logic [exec_pkg::REG_SEL_W-1:0]  ex_writeback_reg_o,
	output logic                            ex_enable_writeback_o,
	output logic [exec_pkg::DATA_W-1:0]     ex_result_o
);

	logic [exec_pkg::DATA_W-1:0]    operand1;
	logic [exec_pkg::DATA_W-1:0]    value2;
	logic [exec_pkg::DATA_W-1:0]    operand2;
	logic [exec_pkg::DATA_W-1:0]    alu_result;
	logic                           is_mul;
	logic                           live;
	logic                           mul_issue;
	logic                           single_valid;
	logic                           writes_pc;
	logic                           branch_taken;
	logic                           is_call;

	logic                           mul_done;
	logic [exec_pkg::DATA_W-1:0]    mul_result;
	logic [exec_pkg::STRAND_W-1:0]  mul_strand;
	logic [exec_pkg::DATA_W-1:0]    mul_pc;
	logic [exec_pkg::REG_SEL_W-1:0] mul_writeback_reg;
	logic                           mul_enable_writeback;

	logic                           valid_nxt;
	logic [exec_pkg::STRAND_W-1:0]  strand_nxt;
	logic [exec_pkg::DATA_W-1:0]    pc_nxt;
	logic [exec_pkg::REG_SEL_W-1:0] writeback_reg_nxt;
	logic                           enable_writeback_nxt;
	logic [exec_pkg::DATA_W-1:0]    result_nxt;

	operand_bypass u_bypass1(
		.sel_i(ds_sel1_i),
		.pc_i(ds_pc_i),
		.reg_value_i(scalar_value1_i),
		.ex_writeback_reg_i(ex_writeback_reg_o),
		.ex_enable_writeback_i(ex_enable_writeback_o),
		.ex_value_i(ex_result_o),
		.ma_writeback_reg_i(ma_writeback_reg_i),
		.ma_enable_writeback_i(ma_enable_writeback_i),
		.ma_value_i(ma_value_i),
		.wb_writeback_reg_i(wb_writeback_reg_i),
		.wb_enable_writeback_i(wb_enable_writeback_i),
		.wb_value_i(wb_value_i),
		.rf_writeback_reg_i(rf_writeback_reg_i),
		.rf_enable_writeback_i(rf_enable_writeback_i),
		.rf_value_i(rf_value_i),
		.value_o(operand1)
	);

	operand_bypass u_bypass2(
		.sel_i(ds_sel2_i),
		.pc_i(ds_pc_i),
		.reg_value_i(scalar_value2_i),
		.ex_writeback_reg_i(ex_writeback_reg_o),
		.ex_enable_writeback_i(ex_enable_writeback_o),
		.ex_value_i(ex_result_o),
		.ma_writeback_reg_i(ma_writeback_reg_i),
		.ma_enable_writeback_i(ma_enable_writeback_i),
		.ma_value_i(ma_value_i),
		.wb_writeback_reg_i(wb_writeback_reg_i),
		.wb_enable_writeback_i(wb_enable_writeback_i),
		.wb_value_i(wb_value_i),
		.rf_writeback_reg_i(rf_writeback_reg_i),
		.rf_enable_writeback_i(rf_enable_writeback_i),
		.rf_value_i(rf_value_i),
		.value_o(value2)
	);

	always_comb
	begin
		case (ds_op2_src_i)
			exec_pkg::OP2_SRC_IMMEDIATE: operand2 = ds_immediate_i;
			default:                     operand2 = value2;
		endcase
	end

	integer_alu u_alu(
		.op_i(ds_alu_op_i),
		.operand1_i(operand1),
		.operand2_i(operand2),
		.result_o(alu_result)
	);

	assign is_mul = ds_alu_op_i == exec_pkg::ALU_MUL;
	assign live = ds_valid_i && !squash_ex0_i;
	assign mul_issue = live && is_mul;
	assign single_valid = live && !is_mul;

	// A multiply result arrives too late to redirect fetch from here
	assign writes_pc = ds_enable_writeback_i && ds_writeback_reg_i == exec_pkg::REG_PC
		&& !is_mul;

	multiply_pipeline u_mul(
		.clk(clk),
		.reset(reset),
		.issue_i(mul_issue),
		.operand1_i(operand1),
		.operand2_i(operand2),
		.strand_i(ds_strand_i),
		.pc_i(ds_pc_i),
		.writeback_reg_i(ds_writeback_reg_i),
		.enable_writeback_i(ds_enable_writeback_i),
		.squash_ex1_i(squash_ex1_i),
		.squash_ex2_i(squash_ex2_i),
		.squash_ex3_i(squash_ex3_i),
		.done_o(mul_done),
		.result_o(mul_result),
		.strand_o(mul_strand),
		.pc_o(mul_pc),
		.writeback_reg_o(mul_writeback_reg),
		.enable_writeback_o(mul_enable_writeback)
	);

	branch_resolver u_branch(
		.valid_i(ds_valid_i),
		.squash_i(squash_ex0_i),
		.branch_i(ds_branch_i),
		.branch_type_i(ds_branch_type_i),
		.offset_i(ds_branch_offset_i),
		.pc_i(ds_pc_i),
		.operand1_i(operand1),
		.alu_result_i(alu_result),
		.writes_pc_i(writes_pc),
		.predicted_i(ds_branch_predicted_i),
		.taken_o(branch_taken),
		.rollback_request_o(ex_rollback_request_o),
		.rollback_pc_o(ex_rollback_pc_o)
	);

	// Calls leave their own PC as the link value
	assign is_call = ds_branch_i && branch_taken
		&& (ds_branch_type_i == exec_pkg::BRANCH_CALL_OFFSET
		|| ds_branch_type_i == exec_pkg::BRANCH_CALL_REGISTER);

	// A finishing multiply has priority at the merge point
	always_comb
	begin
		valid_nxt = 1'b0;
		strand_nxt = ds_strand_i;
		pc_nxt = ds_pc_i;
		writeback_reg_nxt = ds_writeback_reg_i;
		enable_writeback_nxt = 1'b0;
		result_nxt = is_call ? ds_pc_i : alu_result;
		if (mul_done)
		begin
			valid_nxt = 1'b1;
			strand_nxt = mul_strand;
			pc_nxt = mul_pc;
			writeback_reg_nxt = mul_writeback_reg;
			enable_writeback_nxt = mul_enable_writeback;
			result_nxt = mul_result;
		end
		else if (single_valid)
		begin
			valid_nxt = 1'b1;
			enable_writeback_nxt = ds_enable_writeback_i;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ex_valid_o <= 1'b0;
			ex_enable_writeback_o <= 1'b0;
		end
		else
		begin
			ex_valid_o <= valid_nxt;
			ex_enable_writeback_o <= enable_writeback_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_strand_o <= strand_nxt;
		ex_pc_o <= pc_nxt;
		ex_writeback_reg_o <= writeback_reg_nxt;
		ex_result_o <= result_nxt;
	end

endmodule

// File: logic/integer_alu.sv
////////////////////////////////////////////////////////////////////////////
// Combinational single-cycle integer ALU.
// Shifts use the low five bits of operand 2. Compares return 0 or 1.
// Multiply is handled by the multiply pipeline, so its result here is 0.
////////////////////////////////////////////////////////////////////////////

module integer_alu(
	input  exec_pkg::alu_op_t           op_i,
	input  logic [exec_pkg::DATA_W-1:0] operand1_i,
	input  logic [exec_pkg::DATA_W-1:0] operand2_i,
	output logic [exec_pkg::DATA_W-1:0] result_o
);

	logic [4:0] shift_amount;

	assign shift_amount = operand2_i[4:0];

	always_comb
	begin
		result_o = '0;
		case (op_i)
			exec_pkg::ALU_ADD:
				result_o = operand1_i + operand2_i;

			exec_pkg::ALU_SUB:
				result_o = operand1_i - operand2_i;

			exec_pkg::ALU_AND:
				result_o = operand1_i & operand2_i;

			exec_pkg::ALU_OR:
				result_o = operand1_i | operand2_i;

			exec_pkg::ALU_XOR:
				result_o = operand1_i ^ operand2_i;

			exec_pkg::ALU_SHL:
				result_o = operand1_i << shift_amount;

			exec_pkg::ALU_SHR:
				result_o = operand1_i >> shift_amount;

			// Compare results land in bit 0
			exec_pkg::ALU_SEQ:
				result_o[0] = operand1_i == operand2_i;

			exec_pkg::ALU_SLTU:
				result_o[0] = operand1_i < operand2_i;

			exec_pkg::ALU_MOVE:
				result_o = operand2_i;

			default:
				result_o = '0;
		endcase
	end

endmodule

// File: logic/multiply_pipeline.sv
////////////////////////////////////////////////////////////////////////////
// Three-stage 32x32 multiplier keeping the low 32 bits of the product.
// Assumes 32-bit data, as the operand is split into 16-bit halves.
// Writeback tags travel with each item and a squash kills an item as it
// leaves its stage. done_o already has the stage 3 squash applied.
////////////////////////////////////////////////////////////////////////////

module multiply_pipeline(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            issue_i,
	input  logic [exec_pkg::DATA_W-1:0]     operand1_i,
	input  logic [exec_pkg::DATA_W-1:0]     operand2_i,
	input  logic [exec_pkg::STRAND_W-1:0]   strand_i,
	input  logic [exec_pkg::DATA_W-1:0]     pc_i,
	input  logic [exec_pkg::REG_SEL_W-1:0]  writeback_reg_i,
	input  logic                            enable_writeback_i,
	input  logic                            squash_ex1_i,
	input  logic                            squash_ex2_i,
	input  logic                            squash_ex3_i,
	output logic                            done_o,
	output logic [exec_pkg::DATA_W-1:0]     result_o,
	output logic [exec_pkg::STRAND_W-1:0]   strand_o,
	output logic [exec_pkg::DATA_W-1:0]     pc_o,
	output logic [exec_pkg::REG_SEL_W-1:0]  writeback_reg_o,
	output logic                            enable_writeback_o
);

	// Index 0 is stage 1
	logic [exec_pkg::MUL_STAGES-1:0]                          stage_valid;
	logic [exec_pkg::MUL_STAGES-1:0][exec_pkg::STRAND_W-1:0]  strand_q;
	logic [exec_pkg::MUL_STAGES-1:0][exec_pkg::DATA_W-1:0]    pc_q;
	logic [exec_pkg::MUL_STAGES-1:0][exec_pkg::REG_SEL_W-1:0] writeback_reg_q;
	logic [exec_pkg::MUL_STAGES-1:0]                          enable_writeback_q;

	// Squash applied as an item moves out of stage 1 and stage 2
	logic [exec_pkg::MUL_STAGES-2:0] squash_move;

	// Product datapath
	logic [exec_pkg::DATA_W-1:0] op1_q;
	logic [exec_pkg::DATA_W-1:0] op2_q;
	logic [exec_pkg::DATA_W-1:0] part_lo_q;
	logic [15:0]                 part_hi_q;
	logic [exec_pkg::DATA_W-1:0] product_q;

	assign squash_move = {squash_ex2_i, squash_ex1_i};

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			stage_valid <= '0;
		else
		begin
			stage_valid[0] <= issue_i;
			for (int i = 1; i < exec_pkg::MUL_STAGES; i++)
				stage_valid[i] <= stage_valid[i - 1] && !squash_move[i - 1];
		end
	end

	always_ff @(posedge clk)
	begin
		strand_q[0] <= strand_i;
		pc_q[0] <= pc_i;
		writeback_reg_q[0] <= writeback_reg_i;
		enable_writeback_q[0] <= enable_writeback_i;
		for (int i = 1; i < exec_pkg::MUL_STAGES; i++)
		begin
			strand_q[i] <= strand_q[i - 1];
			pc_q[i] <= pc_q[i - 1];
			writeback_reg_q[i] <= writeback_reg_q[i - 1];
			enable_writeback_q[i] <= enable_writeback_q[i - 1];
		end

		// Stage 1 captures operands, stage 2 the partial products,
		// stage 3 their sum. Only the low half of the high partial counts
		op1_q <= operand1_i;
		op2_q <= operand2_i;
		part_lo_q <= op1_q * {16'b0, op2_q[15:0]};
		part_hi_q <= op1_q[15:0] * op2_q[31:16];
		product_q <= part_lo_q + {part_hi_q, 16'b0};
	end

	assign done_o = stage_valid[exec_pkg::MUL_STAGES-1] && !squash_ex3_i;
	assign result_o = product_q;
	assign strand_o = strand_q[exec_pkg::MUL_STAGES-1];
	assign pc_o = pc_q[exec_pkg::MUL_STAGES-1];
	assign writeback_reg_o = writeback_reg_q[exec_pkg::MUL_STAGES-1];
	assign enable_writeback_o = enable_writeback_q[exec_pkg::MUL_STAGES-1];

endmodule

// File: logic/operand_bypass.sv
////////////////////////////////////////////////////////////////////////////
// Operand select with bypass from results not yet in the register file.
// Priority is PC register, then ex, ma, wb, rf, then the register file.
// Each enable must already be qualified by its stage's valid bit.
////////////////////////////////////////////////////////////////////////////

module operand_bypass(
	input  logic [exec_pkg::REG_SEL_W-1:0] sel_i,
	input  logic [exec_pkg::DATA_W-1:0]    pc_i,
	input  logic [exec_pkg::DATA_W-1:0]    reg_value_i,

	// Output register of this stage
	input  logic [exec_pkg::REG_SEL_W-1:0] ex_writeback_reg_i,
	input  logic                           ex_enable_writeback_i,
	input  logic [exec_pkg::DATA_W-1:0]    ex_value_i,

	// Memory access stage
	input  logic [exec_pkg::REG_SEL_W-1:0] ma_writeback_reg_i,
	input  logic                           ma_enable_writeback_i,
	input  logic [exec_pkg::DATA_W-1:0]    ma_value_i,

	// Writeback stage
	input  logic [exec_pkg::REG_SEL_W-1:0] wb_writeback_reg_i,
	input  logic                           wb_enable_writeback_i,
	input  logic [exec_pkg::DATA_W-1:0]    wb_value_i,

	// Value being written into the register file this cycle
	input  logic [exec_pkg::REG_SEL_W-1:0] rf_writeback_reg_i,
	input  logic                           rf_enable_writeback_i,
	input  logic [exec_pkg::DATA_W-1:0]    rf_value_i,

	output logic [exec_pkg::DATA_W-1:0]    value_o
);

	always_comb
	begin
		if (sel_i == exec_pkg::REG_PC)
			value_o = pc_i;
		else if (ex_enable_writeback_i && sel_i == ex_writeback_reg_i)
			value_o = ex_value_i;
		else if (ma_enable_writeback_i && sel_i == ma_writeback_reg_i)
			value_o = ma_value_i;
		else if (wb_enable_writeback_i && sel_i == wb_writeback_reg_i)
			value_o = wb_value_i;
		else if (rf_enable_writeback_i && sel_i == rf_writeback_reg_i)
			value_o = rf_value_i;
		else
			value_o = reg_value_i;
	end

endmodule

// File: tests/execute_stage_chk.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks bound into execute_stage.
// mul_issue_i is the multiply issue, mul_done_i the pipeline's done output
// with the stage 3 squash applied.
// error_count holds the number of failed checks.
////////////////////////////////////////////////////////////////////////////

module execute_stage_chk(
	input  logic               clk,
	input  logic               reset,
	input  logic               ds_valid_i,
	input  exec_pkg::alu_op_t  ds_alu_op_i,
	input  logic               mul_issue_i,
	input  logic               mul_done_i,
	input  logic               squash_ex1_i,
	input  logic               squash_ex2_i,
	input  logic               squash_ex3_i,
	input  logic               ex_valid_i
);

	int error_count = 0;

	// Decode may not send a single-cycle op while a multiply merges
	merge_free: assert property (@(posedge clk) disable iff (reset)
		mul_done_i |-> !(ds_valid_i && ds_alu_op_i != exec_pkg::ALU_MUL))
	else
	begin
		error_count++;
		$error("Single-cycle instruction met a finishing multiply");
	end

	// An unsquashed multiply fills the output register four cycles after issue
	mul_latency: assert property (@(posedge clk) disable iff (reset)
		$past(mul_issue_i, 3) && !$past(squash_ex1_i, 2) && !$past(squash_ex2_i)
		&& !squash_ex3_i |=> ex_valid_i)
	else
	begin
		error_count++;
		$error("Unsquashed multiply did not reach the output register in time");
	end

endmodule

// File: tests/execute_stage_tb.sv
////////////////////////////////////////////////////////////////////////////
// Seeded random testbench for execute_stage with a cycle-level model.
// Inputs change on the falling edge. Registered outputs are checked on the
// next falling edge and rollback shortly after the inputs settle.
// Stimulus keeps single-cycle ops away from a merging multiply.
////////////////////////////////////////////////////////////////////////////

module execute_stage_tb;

	localparam int NUM_CYCLES = 2000;
	localparam int RESET_CYCLES = 16;
	// Reset, drain and some slack on top of the stimulus
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;
	localparam int MS = exec_pkg::MUL_STAGES;

	integer seed = 78624;
	int unsigned cycle_count;

	logic clk;
	logic reset;
	logic ds_valid;
	logic [exec_pkg::STRAND_W-1:0] ds_strand;
	logic [exec_pkg::DATA_W-1:0] ds_pc;
	logic [exec_pkg::REG_SEL_W-1:0] ds_sel1;
	logic [exec_pkg::REG_SEL_W-1:0] ds_sel2;
	logic [exec_pkg::DATA_W-1:0] ds_immediate;
	exec_pkg::op2_src_t ds_op2_src;
	exec_pkg::alu_op_t ds_alu_op;
	logic [exec_pkg::REG_SEL_W-1:0] ds_writeback_reg;
	logic ds_enable_writeback;
	logic ds_branch;
	exec_pkg::branch_t ds_branch_type;
	logic [exec_pkg::DATA_W-1:0] ds_branch_offset;
	logic ds_branch_predicted;
	logic [exec_pkg::DATA_W-1:0] scalar_value1;
	logic [exec_pkg::DATA_W-1:0] scalar_value2;
	logic [exec_pkg::REG_SEL_W-1:0] ma_reg;
	logic [exec_pkg::REG_SEL_W-1:0] wb_reg;
	logic [exec_pkg::REG_SEL_W-1:0] rf_reg;
	logic ma_enable;
	logic wb_enable;
	logic rf_enable;
	logic [exec_pkg::DATA_W-1:0] ma_value;
	logic [exec_pkg::DATA_W-1:0] wb_value;
	logic [exec_pkg::DATA_W-1:0] rf_value;
	logic squash_ex0;
	logic squash_ex1;
	logic squash_ex2;
	logic squash_ex3;

	logic ex_rollback_request;
	logic [exec_pkg::DATA_W-1:0] ex_rollback_pc;
	logic ex_valid;
	logic [exec_pkg::STRAND_W-1:0] ex_strand;
	logic [exec_pkg::DATA_W-1:0] ex_pc;
	logic [exec_pkg::REG_SEL_W-1:0] ex_writeback_reg;
	logic ex_enable_writeback;
	logic [exec_pkg::DATA_W-1:0] ex_result;

	// Model of the output register and the model's ex bypass source
	logic m_valid;
	logic m_wen;
	logic [exec_pkg::STRAND_W-1:0] m_strand;
	logic [exec_pkg::DATA_W-1:0] m_pc;
	logic [exec_pkg::REG_SEL_W-1:0] m_wreg;
	logic [exec_pkg::DATA_W-1:0] m_result;

	// Model of the multiply stages with index 0 as stage 1
	logic mp_valid [MS];
	logic mp_wen [MS];
	logic [exec_pkg::STRAND_W-1:0] mp_strand [MS];
	logic [exec_pkg::DATA_W-1:0] mp_pc [MS];
	logic [exec_pkg::REG_SEL_W-1:0] mp_wreg [MS];
	logic [exec_pkg::DATA_W-1:0] mp_product [MS];

	execute_stage u_dut(
		.clk(clk),
		.reset(reset),
		.ds_valid_i(ds_valid),
		.ds_strand_i(ds_strand),
		.ds_pc_i(ds_pc),
		.ds_sel1_i(ds_sel1),
		.ds_sel2_i(ds_sel2),
		.ds_immediate_i(ds_immediate),
		.ds_op2_src_i(ds_op2_src),
		.ds_alu_op_i(ds_alu_op),
		.ds_writeback_reg_i(ds_writeback_reg),
		.ds_enable_writeback_i(ds_enable_writeback),
		.ds_branch_i(ds_branch),
		.ds_branch_type_i(ds_branch_type),
		.ds_branch_offset_i(ds_branch_offset),
		.ds_branch_predicted_i(ds_branch_predicted),
		.scalar_value1_i(scalar_value1),
		.scalar_value2_i(scalar_value2),
		.ma_writeback_reg_i(ma_reg),
		.ma_enable_writeback_i(ma_enable),
		.ma_value_i(ma_value),
		.wb_writeback_reg_i(wb_reg),
		.wb_enable_writeback_i(wb_enable),
		.wb_value_i(wb_value),
		.rf_writeback_reg_i(rf_reg),
		.rf_enable_writeback_i(rf_enable),
		.rf_value_i(rf_value),
		.squash_ex0_i(squash_ex0),
		.squash_ex1_i(squash_ex1),
		.squash_ex2_i(squash_ex2),
		.squash_ex3_i(squash_ex3),
		.ex_rollback_request_o(ex_rollback_request),
		.ex_rollback_pc_o(ex_rollback_pc),
		.ex_valid_o(ex_valid),
		.ex_strand_o(ex_strand),
		.ex_pc_o(ex_pc),
		.ex_writeback_reg_o(ex_writeback_reg),
		.ex_enable_writeback_o(ex_enable_writeback),
		.ex_result_o(ex_result)
	);

	bind execute_stage execute_stage_chk u_chk(
		.clk(clk),
		.reset(reset),
		.ds_valid_i(ds_valid_i),
		.ds_alu_op_i(ds_alu_op_i),
		.mul_issue_i(mul_issue),
		.mul_done_i(mul_done),
		.squash_ex1_i(squash_ex1_i),
		.squash_ex2_i(squash_ex2_i),
		.squash_ex3_i(squash_ex3_i),
		.ex_valid_i(ex_valid_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		cycle_count = 0;
		forever
		begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES)
				abort_run($sformatf("Timeout after %0d cycles, run did not finish",
					cycle_count));
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Stopping at first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
			abort_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
				$time, what, got, expected));
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return rand_word() % n;
	endfunction

	// Zero now and then so zero branches get taken
	function automatic logic [31:0] rand_data();
		if (rand_below(4) == 0)
			return '0;
		return rand_word();
	endfunction

	// Narrow register range so bypass matches are frequent
	function automatic logic [exec_pkg::REG_SEL_W-1:0] pick_reg();
		int unsigned n;
		n = rand_below(6);
		if (n == 5)
			return exec_pkg::REG_PC;
		return 5'(n);
	endfunction

	function automatic logic [31:0] bypass_model(input logic [4:0] sel,
		input logic [31:0] reg_value);
		if (sel == exec_pkg::REG_PC)
			return ds_pc;
		if (m_wen && sel == m_wreg)
			return m_result;
		if (ma_enable && sel == ma_reg)
			return ma_value;
		if (wb_enable && sel == wb_reg)
			return wb_value;
		if (rf_enable && sel == rf_reg)
			return rf_value;
		return reg_value;
	endfunction

	function automatic logic [31:0] alu_model(input exec_pkg::alu_op_t op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			exec_pkg::ALU_ADD:  return a + b;
			exec_pkg::ALU_SUB:  return a - b;
			exec_pkg::ALU_AND:  return a & b;
			exec_pkg::ALU_OR:   return a | b;
			exec_pkg::ALU_XOR:  return a ^ b;
			exec_pkg::ALU_SHL:  return a << b[4:0];
			exec_pkg::ALU_SHR:  return a >> b[4:0];
			exec_pkg::ALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
			exec_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			exec_pkg::ALU_MOVE: return b;
			default:            return '0;
		endcase
	endfunction

	task automatic init_inputs();
		reset = 1'b1;
		ds_valid = 1'b0;
		ds_strand = '0;
		ds_pc = '0;
		ds_sel1 = '0;
		ds_sel2 = '0;
		ds_immediate = '0;
		ds_op2_src = exec_pkg::OP2_SRC_REG2;
		ds_alu_op = exec_pkg::ALU_ADD;
		ds_writeback_reg = '0;
		ds_enable_writeback = 1'b0;
		ds_branch = 1'b0;
		ds_branch_type = exec_pkg::BRANCH_ZERO;
		ds_branch_offset = '0;
		ds_branch_predicted = 1'b0;
		scalar_value1 = '0;
		scalar_value2 = '0;
		{ma_reg, wb_reg, rf_reg} = '0;
		{ma_enable, wb_enable, rf_enable} = '0;
		{ma_value, wb_value, rf_value} = '0;
		{squash_ex0, squash_ex1, squash_ex2, squash_ex3} = '0;
		m_valid = 1'b0;
		m_wen = 1'b0;
		m_strand = '0;
		m_pc = '0;
		m_wreg = '0;
		m_result = '0;
		for (int i = 0; i < MS; i++)
		begin
			mp_valid[i] = 1'b0;
			mp_wen[i] = 1'b0;
			mp_strand[i] = '0;
			mp_pc[i] = '0;
			mp_wreg[i] = '0;
			mp_product[i] = '0;
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		r = rand_word();
		ds_valid = rand_below(4) != 0;
		ds_strand = r[1:0];
		ds_pc = {r[31:2], 2'b00};
		ds_sel1 = pick_reg();
		ds_sel2 = pick_reg();
		ds_immediate = rand_word();
		ds_op2_src = exec_pkg::op2_src_t'(1'(rand_below(2)));
		if (rand_below(4) == 0)
			ds_alu_op = exec_pkg::ALU_MUL;
		else
			ds_alu_op = exec_pkg::alu_op_t'(4'(rand_below(10)));
		ds_writeback_reg = pick_reg();
		ds_enable_writeback = rand_below(4) != 0;
		ds_branch = rand_below(4) == 0;
		ds_branch_type = exec_pkg::branch_t'(3'(rand_below(5)));
		ds_branch_offset = rand_word();
		ds_branch_predicted = rand_below(2) == 1;
		scalar_value1 = rand_data();
		scalar_value2 = rand_data();
		ma_reg = pick_reg();
		wb_reg = pick_reg();
		rf_reg = pick_reg();
		ma_enable = rand_below(2) == 1;
		wb_enable = rand_below(2) == 1;
		rf_enable = rand_below(2) == 1;
		ma_value = rand_data();
		wb_value = rand_data();
		rf_value = rand_data();
		squash_ex0 = rand_below(8) == 0;
		squash_ex1 = rand_below(8) == 0;
		squash_ex2 = rand_below(8) == 0;
		squash_ex3 = rand_below(8) == 0;
		// Merge slot belongs to the finishing multiply
		if (mp_valid[MS-1] && !squash_ex3 && ds_alu_op != exec_pkg::ALU_MUL)
			ds_valid = 1'b0;
	endtask

	// Outputs while reset is held and no instruction is valid
	task automatic confirm_idle_outputs();
		check_value("ex_valid_o in reset", 32'(ex_valid), 32'd0);
		check_value("ex_enable_writeback_o in reset", 32'(ex_enable_writeback), 32'd0);
		check_value("ex_rollback_request_o in reset", 32'(ex_rollback_request), 32'd0);
	endtask

	task automatic check_outputs();
		assert (u_dut.u_chk.error_count == 0)
		else
			abort_run("Bound assertion checker reported a failure");
		check_value("ex_valid_o", 32'(ex_valid), 32'(m_valid));
		check_value("ex_enable_writeback_o", 32'(ex_enable_writeback), 32'(m_wen));
		if (m_valid)
		begin
			check_value("ex_strand_o", 32'(ex_strand), 32'(m_strand));
			check_value("ex_pc_o", ex_pc, m_pc);
			check_value("ex_writeback_reg_o", 32'(ex_writeback_reg), 32'(m_wreg));
			check_value("ex_result_o", ex_result, m_result);
		end
	endtask

	task automatic run_cycle();
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] alu;
		logic [31:0] target;
		logic writes_pc;
		logic taken;
		logic is_call;
		logic live;
		logic is_mul;
		logic rollback;
		check_outputs();
		drive_inputs();
		#1;

		op1 = bypass_model(ds_sel1, scalar_value1);
		if (ds_op2_src == exec_pkg::OP2_SRC_IMMEDIATE)
			op2 = ds_immediate;
		else
			op2 = bypass_model(ds_sel2, scalar_value2);
		alu = alu_model(ds_alu_op, op1, op2);
		is_mul = ds_alu_op == exec_pkg::ALU_MUL;
		live = ds_valid && !squash_ex0;

		// Branch outcome and rollback in the same cycle
		writes_pc = ds_enable_writeback && ds_writeback_reg == exec_pkg::REG_PC && !is_mul;
		taken = 1'b0;
		target = ds_pc + ds_branch_offset;
		if (writes_pc)
		begin
			taken = 1'b1;
			target = alu;
		end
		else if (ds_branch)
		begin
			if (ds_branch_type == exec_pkg::BRANCH_ZERO)
				taken = op1 == 0;
			else if (ds_branch_type == exec_pkg::BRANCH_NOT_ZERO)
				taken = op1 != 0;
			else
				taken = 1'b1;
			if (ds_branch_type == exec_pkg::BRANCH_CALL_REGISTER)
				target = op1;
		end
		rollback = live && taken != ds_branch_predicted;
		check_value("ex_rollback_request_o", 32'(ex_rollback_request), 32'(rollback));
		if (rollback)
			check_value("ex_rollback_pc_o", ex_rollback_pc, taken ? target : ds_pc);
		is_call = ds_branch && taken && (ds_branch_type == exec_pkg::BRANCH_CALL_OFFSET
			|| ds_branch_type == exec_pkg::BRANCH_CALL_REGISTER);

		// Output register after the coming rising edge
		m_valid = 1'b0;
		m_wen = 1'b0;
		if (mp_valid[MS-1] && !squash_ex3)
		begin
			m_valid = 1'b1;
			m_wen = mp_wen[MS-1];
			m_strand = mp_strand[MS-1];
			m_pc = mp_pc[MS-1];
			m_wreg = mp_wreg[MS-1];
			m_result = mp_product[MS-1];
		end
		else if (live && !is_mul)
		begin
			m_valid = 1'b1;
			m_wen = ds_enable_writeback;
			m_strand = ds_strand;
			m_pc = ds_pc;
			m_wreg = ds_writeback_reg;
			m_result = is_call ? ds_pc : alu;
		end

		// Multiply stages advance and a squash kills an item as it leaves
		mp_valid[2] = mp_valid[1] && !squash_ex2;
		mp_valid[1] = mp_valid[0] && !squash_ex1;
		for (int i = MS - 1; i > 0; i--)
		begin
			mp_wen[i] = mp_wen[i - 1];
			mp_strand[i] = mp_strand[i - 1];
			mp_pc[i] = mp_pc[i - 1];
			mp_wreg[i] = mp_wreg[i - 1];
			mp_product[i] = mp_product[i - 1];
		end
		mp_valid[0] = live && is_mul;
		mp_wen[0] = ds_enable_writeback;
		mp_strand[0] = ds_strand;
		mp_pc[0] = ds_pc;
		mp_wreg[0] = ds_writeback_reg;
		mp_product[0] = op1 * op2;
	endtask

	initial
	begin
		init_inputs();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		confirm_idle_outputs();
		reset = 1'b0;
		for (int n = 0; n < NUM_CYCLES; n++)
		begin
			run_cycle();
			@(negedge clk);
		end
		check_outputs();
		if (u_dut.u_chk.error_count == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			abort_run("Bound assertion checker reported a failure");
	end

endmodule
